// File: design/cordic_pkg.sv
package cordic_pkg;

    // Signed datapath words for the rotation
    typedef logic signed [17:0] angle_t;
    typedef logic signed [17:0] word_t;

    // Phase accumulator word, also read as quadrant and quarter-turn offset
    typedef union packed {
        logic [17:0] raw;
        struct packed {
            logic [1:0]  quadrant;
            logic [15:0] offset;  // Fraction of a quarter turn
        } part;
    } phase_t;

    parameter int FIX_SHIFT = 15;               // Fractional bits of angles and amplitudes
    parameter int ITERATIONS = 16;

    parameter angle_t HALF_PI = 18'sd51472;     // pi/2 at 2^15
    parameter word_t AG_CONST = 18'sd19898;     // 0.607253 gain compensation

    // atan(2^-i) at 2^15
    parameter angle_t ATAN_TABLE [ITERATIONS] = '{
        18'sd25736,
        18'sd15192,
        18'sd8027,
        18'sd4074,
        18'sd2045,
        18'sd1023,
        18'sd511,
        18'sd255,
        18'sd127,
        18'sd63,
        18'sd31,
        18'sd15,
        18'sd7,
        18'sd3,
        18'sd1,
        18'sd0      // Below one LSB
    };

endpackage

// File: design/dtmf_regs_pkg.sv
package dtmf_regs_pkg;

    parameter int WB_DATA_W = 32;

    // Word addresses
    parameter logic [2:0] REG_CTRL      = 3'd0;   // Run, trigger, clear
    parameter logic [2:0] REG_FREQ_LOW  = 3'd1;   // Low tone step
    parameter logic [2:0] REG_FREQ_HIGH = 3'd2;   // High tone step
    parameter logic [2:0] REG_STATUS    = 3'd3;   // Busy and sample count
    parameter logic [2:0] REG_SAMPLE    = 3'd4;   // Last averaged sample
    parameter logic [2:0] REG_PHASE_LOW = 3'd5;   // Low tone accumulator

    // CTRL bit positions
    // Run is a level, the other two act as one-shot commands
    parameter int CTRL_RUN     = 0;
    parameter int CTRL_TRIGGER = 1;
    parameter int CTRL_CLEAR   = 2;

endpackage

// File: design/cordic_sine.sv
`timescale 1ns/1ps

module cordic_sine (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  cordic_pkg::angle_t target,  // First quadrant only
    output logic               done,
    output logic signed [15:0] sine
);
    import cordic_pkg::*;

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_INIT    = 2'd1;
    localparam logic [1:0] S_COMPUTE = 2'd2;
    localparam logic [1:0] S_DONE    = 2'd3;

    // Output clamp at unity
    localparam word_t SINE_MAX = word_t'((1 <<< FIX_SHIFT) - 1);
    localparam word_t SINE_MIN = word_t'(-(1 <<< FIX_SHIFT));

    logic [1:0] state;
    logic [4:0] iter;       // Iteration index
    word_t      x;
    word_t      y;
    angle_t     angle;      // Accumulated rotation
    angle_t     step;
    word_t      x_shift;
    word_t      y_shift;
    logic       rotate_up;

    assign step      = ATAN_TABLE[iter[3:0]];
    assign x_shift   = x >>> iter;      // Arithmetic
    assign y_shift   = y >>> iter;
    assign rotate_up = target > angle;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start)
                        state <= S_INIT;
                end
                S_INIT: begin
                    state <= S_COMPUTE;
                    iter  <= '0;
                end
                S_COMPUTE: begin
                    iter <= iter + 5'd1;
                    if (iter == 5'(ITERATIONS - 1))
                        state <= S_DONE;    // Last step this cycle
                end
                default: state <= start ? S_INIT : S_IDLE;
            endcase
        end
    end

    // Rotation datapath
    always_ff @(posedge clk) begin
        if (state == S_INIT) begin
            x     <= AG_CONST;  // Pre-scaled so the result needs no gain fix
            y     <= '0;
            angle <= '0;
        end else if (state == S_COMPUTE) begin
            if (rotate_up) begin
                x     <= x - y_shift;
                y     <= y + x_shift;
                angle <= angle + step;
            end else begin
                x     <= x + y_shift;
                y     <= y - x_shift;
                angle <= angle - step;
            end
        end
    end

    assign done = (state == S_DONE);
    assign sine = (y > SINE_MAX) ? SINE_MAX[15:0] :
                  (y < SINE_MIN) ? SINE_MIN[15:0] : y[15:0];

endmodule

// File: design/tone_channel.sv
`timescale 1ns/1ps

module tone_channel (
    input  logic               clk,
    input  logic               reset,
    input  logic               clear,   // Zero the accumulator
    input  logic               start,
    input  logic [17:0]        freq,    // Phase step per sample
    output cordic_pkg::phase_t phase,
    output logic               done,
    output logic signed [15:0] sine
);
    import cordic_pkg::*;

    logic [16:0]        folded;     // 65536 stands for a full quarter turn
    logic [32:0]        scaled;
    angle_t             target;
    logic               negate;     // Lower half of the circle
    logic               cordic_done;
    logic signed [15:0] cordic_out;

    // Mirror the offset in quadrants 1 and 3
    assign folded = phase.part.quadrant[0] ? 17'(17'd65536 - phase.part.offset)
                                           : {1'b0, phase.part.offset};
    assign scaled = folded * 33'(HALF_PI);

    // Captured at start, held for the whole rotation
    always_ff @(posedge clk) begin
        if (start) begin
            target <= angle_t'({1'b0, scaled[32:16]});
            negate <= phase.part.quadrant[1];
        end
    end

    cordic_sine i_cordic_sine (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .target (target),
        .done   (cordic_done),
        .sine   (cordic_out)
    );

    // One extra stage for the sign restore
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else
            done <= cordic_done;
    end

    always_ff @(posedge clk) begin
        if (cordic_done)
            sine <= negate ? -cordic_out : cordic_out;
    end

    // Step once per sample, wraps at a full turn
    always_ff @(posedge clk) begin
        if (reset || clear)
            phase.raw <= '0;
        else if (done)
            phase.raw <= phase.raw + freq;
    end

endmodule

// File: design/tone_combiner.sv
`timescale 1ns/1ps

module tone_combiner #(
    parameter int rate_div = 32     // Cycles between free-running samples
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic               trigger,
    input  logic               clear,
    input  logic               done_low,
    input  logic               done_high,
    input  logic signed [15:0] sine_low,
    input  logic signed [15:0] sine_high,
    output logic               start,
    output logic               busy,
    output logic signed [15:0] sample,
    output logic [15:0]        sample_count
);

    localparam int CNT_W = $clog2(rate_div);

    logic [CNT_W-1:0]   rate_cnt;
    logic               rate_hit;
    logic               fire;           // Launch a sample this cycle
    logic               seen_low;
    logic               seen_high;
    logic               both_seen;
    logic signed [16:0] sum;

    assign rate_hit  = run && (rate_cnt == CNT_W'(rate_div - 1));
    assign fire      = !busy && (trigger || rate_hit);  // Ignored while busy
    assign both_seen = busy && (seen_low || done_low) && (seen_high || done_high);
    assign sum       = sine_low + sine_high;            // One bit of headroom

    // Counts from the last launch, parks on the hit until free
    always_ff @(posedge clk) begin
        if (reset || !run || fire)
            rate_cnt <= '0;
        else if (!rate_hit)
            rate_cnt <= rate_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start     <= 1'b0;
            busy      <= 1'b0;
            seen_low  <= 1'b0;
            seen_high <= 1'b0;
        end else begin
            start <= fire;
            if (fire)
                busy <= 1'b1;
            else if (both_seen)
                busy <= 1'b0;
            // Remember a channel that finished first
            if (fire || both_seen) begin
                seen_low  <= 1'b0;
                seen_high <= 1'b0;
            end else if (busy) begin
                seen_low  <= seen_low || done_low;
                seen_high <= seen_high || done_high;
            end
        end
    end

    // Average, channel sines hold until their next done
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sample       <= '0;
            sample_count <= '0;
        end else if (both_seen) begin
            sample       <= sum[16:1];
            sample_count <= sample_count + 16'd1;
        end
    end

endmodule

// File: design/wb_dtmf_regs.sv
`timescale 1ns/1ps

module wb_dtmf_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [2:0]                          wb_adr,
    input  logic [dtmf_regs_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [dtmf_regs_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                                wb_ack,
    output logic                                run,
    output logic                                trigger,    // Pulse
    output logic                                clear,      // Pulse
    output logic [17:0]                         freq_low,
    output logic [17:0]                         freq_high,
    input  logic                                busy,
    input  logic signed [15:0]                  sample,
    input  logic [15:0]                         sample_count,
    input  cordic_pkg::phase_t                  phase_low
);
    import dtmf_regs_pkg::*;

    logic                 access;   // New cycle, not yet acked
    logic                 wr;
    logic                 rd;
    logic [WB_DATA_W-1:0] rd_data;

    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr     = access && wb_we;
    assign rd     = access && !wb_we;

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            REG_CTRL:      rd_data[CTRL_RUN] = run;     // Command bits read 0
            REG_FREQ_LOW:  rd_data = WB_DATA_W'(freq_low);
            REG_FREQ_HIGH: rd_data = WB_DATA_W'(freq_high);
            REG_STATUS: begin
                rd_data[0]                 = busy;
                rd_data[WB_DATA_W-1 -: 16] = sample_count;
            end
            REG_SAMPLE:    rd_data = WB_DATA_W'(sample);    // Sign-extends
            REG_PHASE_LOW: rd_data = WB_DATA_W'(phase_low.raw);
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            run       <= 1'b0;
            trigger   <= 1'b0;
            clear     <= 1'b0;
            freq_low  <= '0;
            freq_high <= '0;
        end else begin
            wb_ack  <= access;      // Single cycle ack
            trigger <= wr && (wb_adr == REG_CTRL) && wb_dat_i[CTRL_TRIGGER];
            clear   <= wr && (wb_adr == REG_CTRL) && wb_dat_i[CTRL_CLEAR];
            if (wr) begin
                case (wb_adr)
                    REG_CTRL:      run       <= wb_dat_i[CTRL_RUN];
                    REG_FREQ_LOW:  freq_low  <= wb_dat_i[17:0];
                    REG_FREQ_HIGH: freq_high <= wb_dat_i[17:0];
                    default: ;  // Read-only words
                endcase
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (rd)
            wb_dat_o <= rd_data;
    end

endmodule

// File: design/dtmf_gen.sv
`timescale 1ns/1ps

module dtmf_gen #(
    parameter int rate_div = 32     // At least 24
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [2:0]                          wb_adr,
    input  logic [dtmf_regs_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [dtmf_regs_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                                wb_ack,
    output logic signed [15:0]                  sample
);
    import cordic_pkg::*;

    logic               run;
    logic               trigger;
    logic               clear;
    logic [17:0]        freq_low;
    logic [17:0]        freq_high;
    logic               busy;
    logic [15:0]        sample_count;
    phase_t             phase_low;
    logic               start;      // Shared by both channels
    logic               done_low;
    logic               done_high;
    logic signed [15:0] sine_low;
    logic signed [15:0] sine_high;

    wb_dtmf_regs i_wb_dtmf_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .run          (run),
        .trigger      (trigger),
        .clear        (clear),
        .freq_low     (freq_low),
        .freq_high    (freq_high),
        .busy         (busy),
        .sample       (sample),
        .sample_count (sample_count),
        .phase_low    (phase_low)
    );

    tone_channel i_tone_low (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .start (start),
        .freq  (freq_low),
        .phase (phase_low),
        .done  (done_low),
        .sine  (sine_low)
    );

    // High tone phase is not read back
    tone_channel i_tone_high (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .start (start),
        .freq  (freq_high),
        .phase (),
        .done  (done_high),
        .sine  (sine_high)
    );

    tone_combiner #(
        .rate_div (rate_div)
    ) i_tone_combiner (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .trigger      (trigger),
        .clear        (clear),
        .done_low     (done_low),
        .done_high    (done_high),
        .sine_low     (sine_low),
        .sine_high    (sine_high),
        .start        (start),
        .busy         (busy),
        .sample       (sample),
        .sample_count (sample_count)
    );

endmodule

// File: testbench/tb_dtmf_ref.svh
`ifndef TB_DTMF_REF_SVH
`define TB_DTMF_REF_SVH

// Expected sine of one 18-bit phase word
function automatic logic signed [15:0] ref_sine(input logic [17:0] phase);
    logic [1:0]         quad;
    logic [16:0]        off;
    longint             prod;
    logic signed [17:0] tgt;
    logic signed [17:0] x;
    logic signed [17:0] y;
    logic signed [17:0] ang;
    logic signed [17:0] x_next;
    logic signed [17:0] y_next;
    logic signed [15:0] s;
    quad = phase[17:16];
    // Odd quadrants run backwards from a quarter turn
    off  = quad[0] ? 17'(65536 - phase[15:0]) : {1'b0, phase[15:0]};
    prod = longint'(off) * longint'(HALF_PI);
    tgt  = 18'(prod >>> 16);   // Radians at 2^15
    x    = AG_CONST;
    y    = '0;
    ang  = '0;
    for (int i = 0; i < ITERATIONS; i++) begin
        if (tgt > ang) begin
            x_next = x - (y >>> i);
            y_next = y + (x >>> i);
            ang    = ang + ATAN_TABLE[i];
        end else begin
            x_next = x + (y >>> i);
            y_next = y - (x >>> i);
            ang    = ang - ATAN_TABLE[i];
        end
        x = x_next;
        y = y_next;
    end
    if (y > 32767)
        s = 16'sd32767;
    else if (y < -32768)
        s = -16'sd32768;
    else
        s = y[15:0];
    if (quad[1])
        s = -s;     // Lower half of the circle
    return s;
endfunction

// Two tones averaged, floor of the halved sum
function automatic logic signed [15:0] ref_sample(input logic [17:0] ph_a,
                                                  input logic [17:0] ph_b);
    int sum;
    sum = int'(ref_sine(ph_a)) + int'(ref_sine(ph_b));
    return 16'(sum >>> 1);
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

// File: testbench/tb_dtmf_gen.sv
`timescale 1ns/1ps

module tb_dtmf_gen;
    import cordic_pkg::*;
    import dtmf_regs_pkg::*;

    `include "tb_dtmf_ref.svh"

    localparam int ACK_TIMEOUT = 20;    // Cycles per bus access
    localparam int IDLE_POLLS  = 40;    // STATUS reads before giving up
    localparam int RUN_CYCLES  = 400;   // Free-running window

    logic               clk;
    logic               reset;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [2:0]         wb_adr;
    logic [31:0]        wb_dat_i;
    logic [31:0]        wb_dat_o;
    logic               wb_ack;
    logic signed [15:0] sample;

    int          checks;
    int          mismatches;
    int          timeouts;
    logic [31:0] rng;
    logic [17:0] ph_low;    // Phases as the DUT should hold them
    logic [17:0] ph_high;
    logic [17:0] f_low;
    logic [17:0] f_high;

    dtmf_gen #(
        .rate_div (32)
    ) i_dtmf_gen (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .sample   (sample)
    );

    always #20 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
            mismatches++;
        end
    endtask

    // One classic cycle driven 2 ns after the edge
    task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int n;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        n = 0;
        @(posedge clk);
        #2;
        while (!wb_ack && n < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!wb_ack) begin
            $display("Timeout at %0t: no Wishbone ack for address %0d", $time, adr);
            timeouts++;
        end
        rdata  = wb_dat_o;  // Registered together with ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        status = 32'h1;
        polls  = 0;
        while (status[0] && polls < IDLE_POLLS) begin
            wb_read(REG_STATUS, status);
            polls++;
        end
        if (status[0] !== 1'b0) begin
            $display("Timeout at %0t: busy never cleared", $time);
            timeouts++;
        end
    endtask

    task automatic set_freqs(input logic [17:0] lo, input logic [17:0] hi);
        logic [31:0] rd;
        wb_write(REG_FREQ_LOW, 32'(lo));
        wb_write(REG_FREQ_HIGH, 32'(hi));
        f_low  = lo;
        f_high = hi;
        wb_read(REG_FREQ_LOW, rd);
        check("freq_low readback", rd, 32'(lo));
        wb_read(REG_FREQ_HIGH, rd);
        check("freq_high readback", rd, 32'(hi));
    endtask

    task automatic clear_all();
        wb_write(REG_CTRL, 32'h1 << CTRL_CLEAR);
        ph_low  = '0;
        ph_high = '0;
    endtask

    // Trigger, wait, compare, then step the model phases
    task automatic triggered_sample(input string what);
        logic [31:0]        rd;
        logic signed [15:0] exp;
        exp = ref_sample(ph_low, ph_high);
        wb_write(REG_CTRL, 32'h1 << CTRL_TRIGGER);
        wait_idle();
        wb_read(REG_SAMPLE, rd);
        check(what, rd, 32'(exp));  // Sign-extended
        check({what, " port"}, 32'(sample), 32'(exp));
        ph_low  = ph_low + f_low;   // Wraps at a full turn
        ph_high = ph_high + f_high;
        wb_read(REG_PHASE_LOW, rd);
        check({what, " phase"}, rd, 32'(ph_low));
    endtask

    initial begin
        logic [31:0]        rd;
        logic [15:0]        count;
        logic [15:0]        n_run;
        logic signed [15:0] exp;
        clk        = 1'b0;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        rng        = 32'd50;
        ph_low     = '0;
        ph_high    = '0;
        f_low      = '0;
        f_high     = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        // Everything readable starts at zero
        for (int a = 0; a <= 5; a++) begin
            wb_read(3'(a), rd);
            check($sformatf("reset value of address %0d", a), rd, 32'h0);
        end

        // Random tones with one sample each
        for (int k = 0; k < 40; k++) begin
            rng = xorshift32(rng);
            f_low = rng[17:0];
            rng = xorshift32(rng);
            set_freqs(f_low, rng[17:0]);
            triggered_sample($sformatf("single sample %0d", k));
        end

        // High tone parked at zero while the low tone walks the quadrants
        clear_all();
        set_freqs(18'd65536, 18'd0);    // Quadrant edges
        for (int k = 0; k < 4; k++)
            triggered_sample($sformatf("quadrant edge %0d", k));
        set_freqs(18'd16384 + 18'd517, 18'd0);
        for (int k = 0; k < 16; k++)
            triggered_sample($sformatf("quadrant sweep %0d", k));

        // Clear drops count, sample and phase
        set_freqs(18'd23011, 18'd40960);
        triggered_sample("before clear");
        clear_all();
        wb_read(REG_STATUS, rd);
        check("count after clear", 32'(rd[31:16]), 32'h0);
        wb_read(REG_SAMPLE, rd);
        check("sample after clear", rd, 32'h0);
        wb_read(REG_PHASE_LOW, rd);
        check("phase after clear", rd, 32'h0);
        triggered_sample("first after clear");

        // Free-running from phase zero
        clear_all();
        rng = xorshift32(rng);
        f_low = rng[17:0];
        rng = xorshift32(rng);
        set_freqs(f_low, rng[17:0]);
        wb_write(REG_CTRL, 32'h1 << CTRL_RUN);
        wb_read(REG_CTRL, rd);
        check("run readback", rd, 32'h1 << CTRL_RUN);
        repeat (RUN_CYCLES) @(posedge clk);
        wb_write(REG_CTRL, 32'h0);
        wait_idle();
        wb_read(REG_STATUS, rd);
        n_run = rd[31:16];
        check("free-run count nonzero", 32'(n_run != 16'd0), 32'h1);
        wb_read(REG_PHASE_LOW, rd);
        check("free-run phase", rd, 32'(18'(32'(n_run) * 32'(f_low))));
        exp = ref_sample(18'(32'(n_run - 16'd1) * 32'(f_low)),
                         18'(32'(n_run - 16'd1) * 32'(f_high)));
        wb_read(REG_SAMPLE, rd);
        check("free-run last sample", rd, 32'(exp));
        ph_low  = 18'(32'(n_run) * 32'(f_low));
        ph_high = 18'(32'(n_run) * 32'(f_high));

        // Second trigger lands while busy
        wb_read(REG_STATUS, rd);
        count = rd[31:16];
        exp = ref_sample(ph_low, ph_high);
        wb_write(REG_CTRL, 32'h1 << CTRL_TRIGGER);
        wb_write(REG_CTRL, 32'h1 << CTRL_TRIGGER);
        wait_idle();
        wb_read(REG_STATUS, rd);
        check("count after double trigger", 32'(rd[31:16]), 32'(count + 16'd1));
        wb_read(REG_SAMPLE, rd);
        check("sample after double trigger", rd, 32'(exp));

        $display("Checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: dtmf_gen.f
+incdir+testbench
design/cordic_pkg.sv
design/dtmf_regs_pkg.sv
design/cordic_sine.sv
design/tone_channel.sv
design/tone_combiner.sv
design/wb_dtmf_regs.sv
design/dtmf_gen.sv
testbench/tb_dtmf_gen.sv

// File: Bender.yml
package:
  name: dtmf_gen

sources:
  - design/cordic_pkg.sv
  - design/dtmf_regs_pkg.sv
  - design/cordic_sine.sv
  - design/tone_channel.sv
  - design/tone_combiner.sv
  - design/wb_dtmf_regs.sv
  - design/dtmf_gen.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_dtmf_gen.sv
